/* ring_sizes_pkg.sv */
package ring_sizes_pkg;

	////////////////////
	// sample word
	////////////////////

	// two 16-bit halves packed into one memory word
	localparam int sample_w = 32;

	typedef logic [sample_w-1:0] sample_t;

	////////////////////
	// tile memory
	////////////////////

	// one address covers a single tile, never the whole ring
	localparam int addr_w = 8;

	typedef logic [addr_w-1:0] addr_t;

	// entries per tile and ring length used when the top level sets nothing
	localparam int default_depth = 256;
	localparam int default_tiles = 4;

endpackage

/* ring_packet_pkg.sv */
package ring_packet_pkg;

	////////////////////
	// destination
	////////////////////

	// address vector of the consumer that receives a packet
	localparam int dest_w = 8;

	typedef logic [dest_w-1:0] dest_t;

	////////////////////
	// packet layout
	////////////////////

	// destination on top, sample below
	// 40 bits in total for the default sizes
	typedef struct packed {
		dest_t dest;
		ring_sizes_pkg::sample_t sample;
	} packet_t;

	// tap and prefetch packets share this one layout,
	// only the source of the destination differs

endpackage

/* sample_buffer.sv */
module sample_buffer #(
	parameter int depth = ring_sizes_pkg::default_depth
) (
	input logic CLK,
	input logic we,
	input ring_sizes_pkg::addr_t waddr,
	input ring_sizes_pkg::sample_t wdata,
	input ring_sizes_pkg::addr_t raddr_a,
	output ring_sizes_pkg::sample_t rdata_a,
	input ring_sizes_pkg::addr_t raddr_b,
	output ring_sizes_pkg::sample_t rdata_b
);

	// register array, one write port and two read ports
	ring_sizes_pkg::sample_t mem [depth];

	////////////////////
	// write port
	////////////////////

	always_ff @(posedge CLK) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	////////////////////
	// read ports
	////////////////////

	// both reads sample the array before this cycle's write lands
	// so a read of the write address returns the old word
	always_ff @(posedge CLK) begin
		rdata_a <= mem[raddr_a];
		rdata_b <= mem[raddr_b];
	end

endmodule

/* delay_tap.sv */
module delay_tap #(
	parameter int depth = ring_sizes_pkg::default_depth
) (
	input logic CLK,
	input logic rst_n,
	input logic cfg_valid,
	input ring_sizes_pkg::addr_t cfg_delay,
	input ring_packet_pkg::dest_t cfg_dest,
	input logic clear,
	input logic sample_valid,
	input ring_sizes_pkg::addr_t wpos,
	output ring_sizes_pkg::addr_t raddr,
	input ring_sizes_pkg::sample_t rdata,
	output logic tap_valid,
	output ring_packet_pkg::packet_t tap_packet
);

	logic loaded;
	logic pending;
	logic fire;
	ring_sizes_pkg::addr_t delay_q;
	ring_packet_pkg::dest_t dest_q;
	ring_packet_pkg::dest_t pend_dest;

	// one read per sample strobe while a tap is loaded
	assign fire = sample_valid & loaded;

	////////////////////
	// configuration
	////////////////////

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			loaded <= 1'b0;
			pending <= 1'b0;
		end else begin
			pending <= fire;
			// a new configuration in the clear cycle survives
			if (cfg_valid) begin
				loaded <= 1'b1;
			end else if (clear) begin
				loaded <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (cfg_valid) begin
			delay_q <= cfg_delay;
			dest_q <= cfg_dest;
		end
		// hold the destination seen with the strobe, a reload may follow
		if (fire) begin
			pend_dest <= dest_q;
		end
	end

	////////////////////
	// delayed read
	////////////////////

	// write position minus delay, wrapped inside this tile
	always_comb begin
		if (wpos >= delay_q) begin
			raddr = wpos - delay_q;
		end else begin
			raddr = ring_sizes_pkg::addr_t'(int'(wpos) + depth - int'(delay_q));
		end
	end

	// word comes back one cycle after the address
	assign tap_valid = pending;
	assign tap_packet = '{dest: pend_dest, sample: rdata};

endmodule

/* prefetch_burst.sv */
module prefetch_burst #(
	parameter int depth = ring_sizes_pkg::default_depth
) (
	input logic CLK,
	input logic rst_n,
	input logic pf_valid,
	input ring_sizes_pkg::addr_t pf_start,
	input ring_sizes_pkg::addr_t pf_stop,
	input ring_packet_pkg::dest_t pf_dest,
	output ring_sizes_pkg::addr_t raddr,
	input ring_sizes_pkg::sample_t rdata,
	output logic busy,
	output logic packet_valid,
	output ring_packet_pkg::packet_t packet
);

	typedef enum logic {
		st_idle,
		st_run
	} state_t;

	state_t state;
	logic accept;
	logic rd_valid;
	ring_sizes_pkg::addr_t addr_q;
	ring_sizes_pkg::addr_t stop_q;
	ring_packet_pkg::dest_t dest_q;

	// requests during a burst are dropped
	assign accept = pf_valid & ~busy;

	////////////////////
	// sequencer
	////////////////////

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			state <= st_idle;
			rd_valid <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					rd_valid <= 1'b0;
					if (accept) begin
						state <= st_run;
					end
				end
				st_run: begin
					rd_valid <= 1'b1;
					if (addr_q == stop_q) begin
						state <= st_idle;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	// address walk, wraps at the end of the tile
	always_ff @(posedge CLK) begin
		if (accept) begin
			addr_q <= pf_start;
			stop_q <= pf_stop;
			dest_q <= pf_dest;
		end else if (state == st_run) begin
			if (addr_q == ring_sizes_pkg::addr_t'(depth - 1)) begin
				addr_q <= '0;
			end else begin
				addr_q <= addr_q + 1'b1;
			end
		end
	end

	////////////////////
	// packet output
	////////////////////

	assign raddr = addr_q;

	// rd_valid trails the read by one cycle, matching the memory latency
	assign packet_valid = rd_valid;
	assign packet = '{dest: dest_q, sample: rdata};

	// stays up until the last packet has left
	assign busy = (state == st_run) | rd_valid;

endmodule

/* tile_controller.sv */
module tile_controller #(
	parameter int depth = ring_sizes_pkg::default_depth,
	parameter bit first_tile = 1'b0
) (
	input logic CLK,
	input logic rst_n,
	input ring_sizes_pkg::sample_t sample,
	input logic sample_valid,
	input logic write_start,
	input logic token_in,
	output logic token_out,
	input logic cfg_valid,
	input ring_sizes_pkg::addr_t cfg_delay,
	input ring_packet_pkg::dest_t cfg_dest,
	input logic scenario_update,
	input logic pf_valid,
	input ring_sizes_pkg::addr_t pf_start,
	input ring_sizes_pkg::addr_t pf_stop,
	input ring_packet_pkg::dest_t pf_dest,
	output logic tap_valid,
	output ring_packet_pkg::packet_t tap_packet,
	output logic pf_packet_valid,
	output ring_packet_pkg::packet_t pf_packet,
	output logic pf_busy
);

	ring_sizes_pkg::addr_t wpos;
	logic token;
	logic we;
	logic at_wrap;
	ring_sizes_pkg::addr_t raddr_a;
	ring_sizes_pkg::addr_t raddr_b;
	ring_sizes_pkg::sample_t rdata_a;
	ring_sizes_pkg::sample_t rdata_b;

	////////////////////
	// write position and token
	////////////////////

	assign at_wrap = (wpos == ring_sizes_pkg::addr_t'(depth - 1));

	// only the token holder writes the broadcast stream
	assign we = token & sample_valid;

	// hand the token on with the last entry of this tile
	assign token_out = we & at_wrap;

	// every tile counts in step, holder or not
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			wpos <= '0;
		end else if (write_start) begin
			wpos <= '0;
		end else if (sample_valid) begin
			if (at_wrap) begin
				wpos <= '0;
			end else begin
				wpos <= wpos + 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			token <= 1'b0;
		end else if (write_start) begin
			token <= first_tile;
		end else if (token_in) begin
			// also covers a ring of one tile
			token <= 1'b1;
		end else if (token_out) begin
			token <= 1'b0;
		end
	end

	////////////////////
	// memory and readers
	////////////////////

	sample_buffer #(
		.depth(depth)
	) u_buffer (
		.CLK(CLK),
		.we(we),
		.waddr(wpos),
		.wdata(sample),
		.raddr_a(raddr_a),
		.rdata_a(rdata_a),
		.raddr_b(raddr_b),
		.rdata_b(rdata_b)
	);

	// port a
	delay_tap #(
		.depth(depth)
	) u_tap (
		.CLK(CLK),
		.rst_n(rst_n),
		.cfg_valid(cfg_valid),
		.cfg_delay(cfg_delay),
		.cfg_dest(cfg_dest),
		.clear(scenario_update),
		.sample_valid(sample_valid),
		.wpos(wpos),
		.raddr(raddr_a),
		.rdata(rdata_a),
		.tap_valid(tap_valid),
		.tap_packet(tap_packet)
	);

	// port b
	prefetch_burst #(
		.depth(depth)
	) u_prefetch (
		.CLK(CLK),
		.rst_n(rst_n),
		.pf_valid(pf_valid),
		.pf_start(pf_start),
		.pf_stop(pf_stop),
		.pf_dest(pf_dest),
		.raddr(raddr_b),
		.rdata(rdata_b),
		.busy(pf_busy),
		.packet_valid(pf_packet_valid),
		.packet(pf_packet)
	);

endmodule

/* delay_ring_top.sv */
module delay_ring_top #(
	parameter int depth = ring_sizes_pkg::default_depth,
	parameter int n_tiles = ring_sizes_pkg::default_tiles
) (
	input logic CLK,
	input logic rst_n,

	// broadcast sample stream
	input ring_sizes_pkg::sample_t sample,
	input logic sample_valid,
	input logic write_start,

	// tap configuration, one strobe per tile
	input logic [n_tiles-1:0] cfg_valid,
	input ring_sizes_pkg::addr_t cfg_delay,
	input ring_packet_pkg::dest_t cfg_dest,
	input logic scenario_update,

	// prefetch requests, one strobe per tile
	input logic [n_tiles-1:0] pf_valid,
	input ring_sizes_pkg::addr_t pf_start,
	input ring_sizes_pkg::addr_t pf_stop,
	input ring_packet_pkg::dest_t pf_dest,

	// per-tile outputs
	output logic [n_tiles-1:0] tap_valid,
	output ring_packet_pkg::packet_t [n_tiles-1:0] tap_packet,
	output logic [n_tiles-1:0] pf_packet_valid,
	output ring_packet_pkg::packet_t [n_tiles-1:0] pf_packet,
	output logic [n_tiles-1:0] pf_busy
);

	// token_ring[k] is the handoff pulse leaving tile k
	logic [n_tiles-1:0] token_ring;

	////////////////////
	// tile ring
	////////////////////

	for (genvar k = 0; k < n_tiles; k++) begin : g_tile
		tile_controller #(
			.depth(depth),
			.first_tile(k == 0)
		) u_tile (
			.CLK(CLK),
			.rst_n(rst_n),
			.sample(sample),
			.sample_valid(sample_valid),
			.write_start(write_start),
			// previous tile in the ring, the last one feeds tile 0
			.token_in(token_ring[(k + n_tiles - 1) % n_tiles]),
			.token_out(token_ring[k]),
			.cfg_valid(cfg_valid[k]),
			.cfg_delay(cfg_delay),
			.cfg_dest(cfg_dest),
			.scenario_update(scenario_update),
			.pf_valid(pf_valid[k]),
			.pf_start(pf_start),
			.pf_stop(pf_stop),
			.pf_dest(pf_dest),
			.tap_valid(tap_valid[k]),
			.tap_packet(tap_packet[k]),
			.pf_packet_valid(pf_packet_valid[k]),
			.pf_packet(pf_packet[k]),
			.pf_busy(pf_busy[k])
		);
	end

endmodule

/* delay_ring_tb.sv */
module delay_ring_tb;

	localparam int depth = 256;
	localparam int n_tiles = 4;
	localparam int burst_timeout = 600;

	logic CLK;
	logic rst_n;
	ring_sizes_pkg::sample_t sample;
	logic sample_valid;
	logic write_start;
	logic [n_tiles-1:0] cfg_valid;
	ring_sizes_pkg::addr_t cfg_delay;
	ring_packet_pkg::dest_t cfg_dest;
	logic scenario_update;
	logic [n_tiles-1:0] pf_valid;
	ring_sizes_pkg::addr_t pf_start;
	ring_sizes_pkg::addr_t pf_stop;
	ring_packet_pkg::dest_t pf_dest;
	logic [n_tiles-1:0] tap_valid;
	ring_packet_pkg::packet_t [n_tiles-1:0] tap_packet;
	logic [n_tiles-1:0] pf_packet_valid;
	ring_packet_pkg::packet_t [n_tiles-1:0] pf_packet;
	logic [n_tiles-1:0] pf_busy;

	////////////////////
	// reference model
	////////////////////

	ring_sizes_pkg::sample_t mem_m [n_tiles][depth];
	int m_wpos;
	int m_tok;
	bit m_tok_valid;
	bit tap_loaded [n_tiles];
	int tap_delay [n_tiles];
	ring_packet_pkg::dest_t tap_dest [n_tiles];
	bit exp_tap_v [n_tiles];
	logic [39:0] exp_tap_pkt [n_tiles];
	bit busy_now [n_tiles];
	// the one burst in flight runs on tile pf_tile
	int pf_tile;
	int pf_wait;
	logic [39:0] pf_q [$];
	int got_cnt;
	string test_name;
	int ta;
	int tb;
	int s;
	int e;

	delay_ring_top #(
		.depth(depth),
		.n_tiles(n_tiles)
	) DUT (
		.CLK(CLK),
		.rst_n(rst_n),
		.sample(sample),
		.sample_valid(sample_valid),
		.write_start(write_start),
		.cfg_valid(cfg_valid),
		.cfg_delay(cfg_delay),
		.cfg_dest(cfg_dest),
		.scenario_update(scenario_update),
		.pf_valid(pf_valid),
		.pf_start(pf_start),
		.pf_stop(pf_stop),
		.pf_dest(pf_dest),
		.tap_valid(tap_valid),
		.tap_packet(tap_packet),
		.pf_packet_valid(pf_packet_valid),
		.pf_packet(pf_packet),
		.pf_busy(pf_busy)
	);

	always #10 CLK = ~CLK;

	task automatic report_fail(string msg);
		$display("%s", msg);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic value_error(string what, logic [39:0] expv, logic [39:0] actv);
		report_fail($sformatf("ERR %s %s expected %h actual %h", test_name, what, expv, actv));
	endtask

	function automatic int burst_len(int start, int stop);
		return ((stop - start + depth) % depth) + 1;
	endfunction

	// effect of the inputs driven now on the state after the next rising edge
	task automatic apply_model();
		int a;
		for (int k = 0; k < n_tiles; k++) begin
			if (sample_valid && tap_loaded[k]) begin
				a = (m_wpos + depth - tap_delay[k]) % depth;
				exp_tap_v[k] = 1'b1;
				exp_tap_pkt[k] = {tap_dest[k], mem_m[k][a]};
			end
			if (pf_valid[k] && !busy_now[k]) begin
				pf_tile = k;
				pf_wait = 1;
				a = int'(pf_start);
				pf_q.push_back({pf_dest, mem_m[k][a]});
				while (a != int'(pf_stop)) begin
					a = (a + 1) % depth;
					pf_q.push_back({pf_dest, mem_m[k][a]});
				end
			end
			if (cfg_valid[k]) begin
				tap_loaded[k] = 1'b1;
				tap_delay[k] = int'(cfg_delay);
				tap_dest[k] = cfg_dest;
			end else if (scenario_update) begin
				tap_loaded[k] = 1'b0;
			end
		end
		if (write_start) begin
			m_wpos = 0;
			m_tok = 0;
			m_tok_valid = 1'b1;
		end else if (sample_valid) begin
			if (m_tok_valid) begin
				mem_m[m_tok][m_wpos] = sample;
				// token moves on with the last entry of a tile
				if (m_wpos == depth - 1) begin
					m_tok = (m_tok + 1) % n_tiles;
				end
			end
			m_wpos = (m_wpos + 1) % depth;
		end
	endtask

	// outputs are stable at the falling edge
	task automatic tick();
		logic exp_b;
		logic exp_pv;
		logic [39:0] exp_pp;
		@(negedge CLK);
		for (int k = 0; k < n_tiles; k++) begin
			assert (tap_valid[k] === exp_tap_v[k])
				else value_error($sformatf("tap_valid[%0d]", k), exp_tap_v[k], tap_valid[k]);
			if (exp_tap_v[k]) begin
				assert (tap_packet[k] === exp_tap_pkt[k])
					else value_error($sformatf("tap_packet[%0d]", k), exp_tap_pkt[k], tap_packet[k]);
			end
			exp_tap_v[k] = 1'b0;
			exp_b = (k == pf_tile) && (pf_wait > 0 || pf_q.size() > 0);
			assert (pf_busy[k] === exp_b)
				else value_error($sformatf("pf_busy[%0d]", k), exp_b, pf_busy[k]);
			busy_now[k] = exp_b;
			exp_pv = 1'b0;
			exp_pp = '0;
			if (k == pf_tile && pf_wait > 0) begin
				pf_wait--;
			end else if (k == pf_tile && pf_q.size() > 0) begin
				exp_pv = 1'b1;
				exp_pp = pf_q.pop_front();
			end
			assert (pf_packet_valid[k] === exp_pv)
				else value_error($sformatf("pf_packet_valid[%0d]", k), exp_pv,
					pf_packet_valid[k]);
			if (exp_pv) begin
				assert (pf_packet[k] === exp_pp)
					else value_error($sformatf("pf_packet[%0d]", k), exp_pp, pf_packet[k]);
			end
			// packets the DUT actually sent on the burst tile
			if (k == pf_tile && pf_packet_valid[k] === 1'b1) begin
				got_cnt++;
			end
		end
	endtask

	task automatic run_cycle();
		apply_model();
		tick();
		sample_valid = 1'b0;
		write_start = 1'b0;
		cfg_valid = '0;
		pf_valid = '0;
		scenario_update = 1'b0;
	endtask

	task automatic feed_samples(int n);
		repeat (n) begin
			sample = $urandom;
			sample_valid = 1'b1;
			run_cycle();
		end
	endtask

	task automatic configure_tap(int tile, int delay, int dest);
		cfg_delay = delay;
		cfg_dest = dest;
		cfg_valid[tile] = 1'b1;
		run_cycle();
	endtask

	task automatic launch_burst(int tile, int start, int stop, int dest);
		got_cnt = 0;
		pf_start = start;
		pf_stop = stop;
		pf_dest = dest;
		pf_valid[tile] = 1'b1;
		run_cycle();
	endtask

	task automatic finish_burst(int tile, int exp_count);
		int n;
		n = 0;
		while (pf_busy[tile] !== 1'b0) begin
			run_cycle();
			n++;
			if (n > burst_timeout) begin
				report_fail($sformatf("timeout waiting for the burst on tile %0d to end", tile));
			end
		end
		assert (got_cnt == exp_count)
			else value_error("packet count", exp_count, got_cnt);
	endtask

	////////////////////
	// stimulus
	////////////////////

	initial begin
		void'($urandom(77));
		CLK = 1'b0;
		rst_n = 1'b0;
		sample = '0;
		sample_valid = 1'b0;
		write_start = 1'b0;
		cfg_valid = '0;
		cfg_delay = '0;
		cfg_dest = '0;
		scenario_update = 1'b0;
		pf_valid = '0;
		pf_start = '0;
		pf_stop = '0;
		pf_dest = '0;
		m_wpos = 0;
		m_tok = 0;
		m_tok_valid = 1'b0;
		pf_tile = -1;
		pf_wait = 0;
		got_cnt = 0;
		for (int k = 0; k < n_tiles; k++) begin
			tap_loaded[k] = 1'b0;
			exp_tap_v[k] = 1'b0;
			busy_now[k] = 1'b0;
		end
		repeat (2) @(negedge CLK);
		rst_n = 1'b1;

		test_name = "reset_quiet";
		repeat (8) run_cycle();

		// four laps fill the ring and the extra samples overwrite tile 0
		test_name = "ring_fill";
		write_start = 1'b1;
		run_cycle();
		feed_samples(n_tiles * depth + 100);
		for (int t = 0; t < n_tiles; t++) begin
			launch_burst(t, 0, depth - 1, $urandom);
			finish_burst(t, depth);
		end

		test_name = "delay_tap";
		ta = $urandom % n_tiles;
		tb = (ta + 1 + $urandom % (n_tiles - 1)) % n_tiles;
		configure_tap(ta, 1 + $urandom % (depth - 1), $urandom);
		configure_tap(tb, 1 + $urandom % (depth - 1), $urandom);
		feed_samples(300);

		test_name = "prefetch";
		s = $urandom % depth;
		e = $urandom % depth;
		launch_burst(2, s, e, $urandom);
		finish_burst(2, burst_len(s, e));
		// stop below start makes the walk wrap
		s = 200 + $urandom % 56;
		e = $urandom % 50;
		launch_burst(2, s, e, $urandom);
		finish_burst(2, burst_len(s, e));

		test_name = "ignored_request";
		s = $urandom % 100;
		e = s + 20 + $urandom % 100;
		launch_burst(1, s, e, $urandom);
		repeat (3) run_cycle();
		pf_start = $urandom;
		pf_stop = $urandom;
		pf_dest = $urandom;
		pf_valid[1] = 1'b1;
		run_cycle();
		finish_burst(1, burst_len(s, e));
		repeat (6) run_cycle();

		// the strobe in the update cycle still yields its packets
		test_name = "scenario_update";
		sample = $urandom;
		sample_valid = 1'b1;
		scenario_update = 1'b1;
		run_cycle();
		feed_samples(40);
		configure_tap(ta, 1 + $urandom % (depth - 1), $urandom);
		feed_samples(20);

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

/* filelist.f */
ring_sizes_pkg.sv
ring_packet_pkg.sv
sample_buffer.sv
delay_tap.sv
prefetch_burst.sv
tile_controller.sv
delay_ring_top.sv
delay_ring_tb.sv

/* Bender.yml */
package:
  name: delay_ring

sources:
  # packages first, then the ring from the leaves up
  - files:
      - ring_sizes_pkg.sv
      - ring_packet_pkg.sv
      - sample_buffer.sv
      - delay_tap.sv
      - prefetch_burst.sv
      - tile_controller.sv
      - delay_ring_top.sv
  - target: test
    files:
      - delay_ring_tb.sv
